//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE  = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;  // BLTZ / BGEZ, selected by rt
	localparam logic [5:0] OP_BEQ    = 6'h04;
	localparam logic [5:0] OP_BNE    = 6'h05;
	localparam logic [5:0] OP_BLEZ   = 6'h06;
	localparam logic [5:0] OP_BGTZ   = 6'h07;
	localparam logic [5:0] OP_ADDIU  = 6'h09;
	localparam logic [5:0] OP_SLTI   = 6'h0a;
	localparam logic [5:0] OP_SLTIU  = 6'h0b;
	localparam logic [5:0] OP_ANDI   = 6'h0c;
	localparam logic [5:0] OP_ORI    = 6'h0d;
	localparam logic [5:0] OP_XORI   = 6'h0e;
	localparam logic [5:0] OP_LUI    = 6'h0f;

	// REGIMM rt field
	localparam logic [4:0] RT_BLTZ = 5'h00;
	localparam logic [4:0] RT_BGEZ = 5'h01;

	// R-type function codes
	localparam logic [5:0] FN_SLL   = 6'h00;
	localparam logic [5:0] FN_SRL   = 6'h02;
	localparam logic [5:0] FN_SRA   = 6'h03;
	localparam logic [5:0] FN_SLLV  = 6'h04;
	localparam logic [5:0] FN_SRLV  = 6'h06;
	localparam logic [5:0] FN_SRAV  = 6'h07;
	localparam logic [5:0] FN_JR    = 6'h08;
	localparam logic [5:0] FN_MFHI  = 6'h10;
	localparam logic [5:0] FN_MFLO  = 6'h12;
	localparam logic [5:0] FN_MULT  = 6'h18;
	localparam logic [5:0] FN_MULTU = 6'h19;
	localparam logic [5:0] FN_DIV   = 6'h1a;
	localparam logic [5:0] FN_DIVU  = 6'h1b;
	localparam logic [5:0] FN_ADDU  = 6'h21;
	localparam logic [5:0] FN_SUBU  = 6'h23;
	localparam logic [5:0] FN_AND   = 6'h24;
	localparam logic [5:0] FN_OR    = 6'h25;
	localparam logic [5:0] FN_XOR   = 6'h26;
	localparam logic [5:0] FN_NOR   = 6'h27;
	localparam logic [5:0] FN_SLT   = 6'h2a;
	localparam logic [5:0] FN_SLTU  = 6'h2b;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rtype_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} itype_t;

	// Same 32-bit word, two field layouts
	typedef union packed {
		rtype_t r;
		itype_t i;
	} instr_u;

endpackage

`default_nettype wire

//--- alu_pkg.sv
`default_nettype none

package alu_pkg;

	typedef enum logic [4:0] {
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_ADDU,
		ALU_SUBU,
		ALU_SLTU,
		ALU_SLT,
		ALU_SLL,
		ALU_SLLV,
		ALU_SRA,
		ALU_SRL,
		ALU_SRAV,
		ALU_SRLV,
		ALU_LUI,
		ALU_PASS_A,  // JR
		ALU_BLTZ,
		ALU_BGEZ,
		ALU_BGTZ,
		ALU_BLEZ,
		ALU_BEQZ,
		ALU_BNEZ,
		ALU_MULT,
		ALU_MULTU,
		ALU_DIV,
		ALU_DIVU,
		ALU_MFHI,
		ALU_MFLO,
		ALU_NOP
	} alu_op_e;

	typedef struct packed {
		alu_op_e     op;
		logic        use_imm;  // B from imm_val instead of rt
		logic [31:0] imm_val;
		logic [4:0]  shamt;    // Fixed shift distance
	} alu_ctl_t;

	typedef struct packed {
		logic                 valid;
		mips_isa_pkg::instr_u instr;
		logic [31:0]          rs_val;
		logic [31:0]          rt_val;
	} exec_req_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] result;
		logic        zero;
	} exec_rsp_t;

	localparam int MUL_LATENCY = 2;   // Issue to HI/LO holding the product
	localparam int DIV_CYCLES  = 33;  // 32 quotient bits plus sign fixup

endpackage

`default_nettype wire

//--- alu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module alu_decoder (
	input  mips_isa_pkg::instr_u instr,
	output alu_pkg::alu_ctl_t    ctl
);
	import mips_isa_pkg::*;
	import alu_pkg::*;

	logic [31:0] imm_sext;
	logic [31:0] imm_zext;
	logic [31:0] imm_upper;

	assign imm_sext  = {{16{instr.i.imm16[15]}}, instr.i.imm16};
	assign imm_zext  = {16'b0, instr.i.imm16};
	assign imm_upper = {instr.i.imm16, 16'b0};  // LUI placement

	always_comb begin
		ctl.op      = ALU_NOP;
		ctl.use_imm = 1'b0;
		ctl.imm_val = imm_sext;
		ctl.shamt   = 5'd0;
		if (instr.r.opcode == OP_RTYPE) begin
			case (instr.r.funct)
				FN_AND:   ctl.op = ALU_AND;
				FN_OR:    ctl.op = ALU_OR;
				FN_XOR:   ctl.op = ALU_XOR;
				FN_NOR:   ctl.op = ALU_NOR;
				FN_ADDU:  ctl.op = ALU_ADDU;
				FN_SUBU:  ctl.op = ALU_SUBU;
				FN_SLT:   ctl.op = ALU_SLT;
				FN_SLTU:  ctl.op = ALU_SLTU;
				FN_SLLV:  ctl.op = ALU_SLLV;
				FN_SRLV:  ctl.op = ALU_SRLV;
				FN_SRAV:  ctl.op = ALU_SRAV;
				FN_JR:    ctl.op = ALU_PASS_A;
				FN_MULT:  ctl.op = ALU_MULT;
				FN_MULTU: ctl.op = ALU_MULTU;
				FN_DIV:   ctl.op = ALU_DIV;
				FN_DIVU:  ctl.op = ALU_DIVU;
				FN_MFHI:  ctl.op = ALU_MFHI;
				FN_MFLO:  ctl.op = ALU_MFLO;
				FN_SLL: begin
					ctl.op    = ALU_SLL;
					ctl.shamt = instr.r.shamt;
				end
				FN_SRL: begin
					ctl.op    = ALU_SRL;
					ctl.shamt = instr.r.shamt;
				end
				FN_SRA: begin
					ctl.op    = ALU_SRA;
					ctl.shamt = instr.r.shamt;
				end
				default:  ctl.op = ALU_NOP;
			endcase
		end else begin
			ctl.use_imm = 1'b1;  // Cleared again for the branches
			case (instr.i.opcode)
				OP_ADDIU: ctl.op = ALU_ADDU;
				OP_SLTI:  ctl.op = ALU_SLT;
				OP_SLTIU: ctl.op = ALU_SLTU;  // Sign extended, compared unsigned
				OP_ANDI: begin
					ctl.op      = ALU_AND;
					ctl.imm_val = imm_zext;
				end
				OP_ORI: begin
					ctl.op      = ALU_OR;
					ctl.imm_val = imm_zext;
				end
				OP_XORI: begin
					ctl.op      = ALU_XOR;
					ctl.imm_val = imm_zext;
				end
				OP_LUI: begin
					ctl.op      = ALU_LUI;
					ctl.imm_val = imm_upper;
				end
				OP_REGIMM: begin
					ctl.use_imm = 1'b0;
					case (instr.i.rt)
						RT_BLTZ: ctl.op = ALU_BLTZ;
						RT_BGEZ: ctl.op = ALU_BGEZ;
						default: ctl.op = ALU_NOP;
					endcase
				end
				OP_BGTZ: begin
					ctl.op      = ALU_BGTZ;
					ctl.use_imm = 1'b0;
				end
				OP_BLEZ: begin
					ctl.op      = ALU_BLEZ;
					ctl.use_imm = 1'b0;
				end
				OP_BEQ: begin
					ctl.op      = ALU_BEQZ;
					ctl.use_imm = 1'b0;
				end
				OP_BNE: begin
					ctl.op      = ALU_BNEZ;
					ctl.use_imm = 1'b0;
				end
				default: begin
					ctl.op      = ALU_NOP;
					ctl.use_imm = 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- alu_core.sv
`timescale 1ns/100ps
`default_nettype none

module alu_core (
	input  alu_pkg::alu_ctl_t ctl,
	input  logic [31:0]       a,
	input  logic [31:0]       b,
	input  logic [31:0]       hi,
	input  logic [31:0]       lo,
	output logic [31:0]       result,
	output logic              zero
);
	import alu_pkg::*;

	logic        a_neg;     // Sign of rs
	logic        a_is_zero;
	logic        a_pos;     // Strictly greater than zero
	logic        lt_signed;
	logic        lt_unsigned;
	logic [4:0]  var_sh;    // Variable shift distance
	logic [31:0] sum;
	logic [31:0] diff;

	assign a_neg       = a[31];
	assign a_is_zero   = (a == 32'b0);
	assign a_pos       = !a_neg && !a_is_zero;
	assign lt_signed   = ($signed(a) < $signed(b));
	assign lt_unsigned = (a < b);
	assign var_sh      = b[4:0];
	assign sum         = a + b;
	assign diff        = a - b;

	// Branches give 0 when taken, so zero flags the taken case
	always_comb begin
		case (ctl.op)
			ALU_AND:    result = a & b;
			ALU_OR:     result = a | b;
			ALU_XOR:    result = a ^ b;
			ALU_NOR:    result = ~(a | b);
			ALU_ADDU:   result = sum;
			ALU_SUBU:   result = diff;
			ALU_SLT:    result = {31'b0, lt_signed};
			ALU_SLTU:   result = {31'b0, lt_unsigned};
			ALU_SLL:    result = a << ctl.shamt;
			ALU_SRL:    result = a >> ctl.shamt;
			ALU_SRA:    result = $unsigned($signed(a) >>> ctl.shamt);
			ALU_SLLV:   result = a << var_sh;
			ALU_SRLV:   result = a >> var_sh;
			ALU_SRAV:   result = $unsigned($signed(a) >>> var_sh);
			ALU_LUI:    result = b;  // Already shifted up by decode
			ALU_PASS_A: result = a;
			ALU_BLTZ:   result = a_neg ? 32'd0 : 32'd1;
			ALU_BGEZ:   result = !a_neg ? 32'd0 : 32'd1;
			ALU_BGTZ:   result = a_pos ? 32'd0 : 32'd1;
			ALU_BLEZ:   result = !a_pos ? 32'd0 : 32'd1;
			ALU_BEQZ:   result = a_is_zero ? 32'd0 : 32'd1;
			ALU_BNEZ:   result = !a_is_zero ? 32'd0 : 32'd1;
			ALU_MFHI:   result = hi;
			ALU_MFLO:   result = lo;
			default:    result = 32'd0;  // Mul/div and NOP
		endcase
	end

	assign zero = (result == 32'b0);

endmodule

`default_nettype wire

//--- muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
	input  logic             clk,
	input  logic             rst,
	input  logic             start,
	input  alu_pkg::alu_op_e op,
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	output logic             busy,
	output logic [31:0]      hi,
	output logic [31:0]      lo
);
	import alu_pkg::*;

	logic        is_mul;
	logic        is_div;
	logic        is_signed;
	logic [63:0] mul_a;       // Extended to 64 bits per signedness
	logic [63:0] mul_b;
	logic [63:0] mul_prod;    // Stage 1 product
	logic        mul_vld;
	logic [5:0]  busy_cnt;
	logic        div_act;
	logic        div_last;
	logic [31:0] div_rem;
	logic [31:0] div_quo;     // Dividend shifts out, quotient shifts in
	logic [31:0] div_dvs;
	logic        div_neg_q;
	logic        div_neg_r;
	logic        div_by_zero;
	logic [32:0] div_shift;
	logic [32:0] div_diff;
	logic        div_ge;

	assign is_mul    = (op == ALU_MULT) || (op == ALU_MULTU);
	assign is_div    = (op == ALU_DIV) || (op == ALU_DIVU);
	assign is_signed = (op == ALU_MULT) || (op == ALU_DIV);
	assign mul_a     = {(is_signed ? {32{a[31]}} : 32'b0), a};
	assign mul_b     = {(is_signed ? {32{b[31]}} : 32'b0), b};
	assign busy      = (busy_cnt != 6'd0);
	assign div_last  = div_act && (busy_cnt == 6'd1);

	// One restoring step
	assign div_shift = {div_rem, div_quo[31]};
	assign div_diff  = div_shift - {1'b0, div_dvs};
	assign div_ge    = (div_shift >= {1'b0, div_dvs});

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_cnt <= 6'd0;
			div_act  <= 1'b0;
			mul_vld  <= 1'b0;
		end else begin
			mul_vld <= start && is_mul;
			if (start && is_mul) begin
				busy_cnt <= 6'(MUL_LATENCY);
			end else if (start && is_div) begin
				busy_cnt <= 6'(DIV_CYCLES);
			end else if (busy) begin
				busy_cnt <= busy_cnt - 6'd1;
			end
			if (start && is_div) begin
				div_act <= 1'b1;
			end else if (div_last) begin
				div_act <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && is_mul) begin
			mul_prod <= mul_a * mul_b;  // Low 64 bits are right for both signs
		end
		if (start && is_div) begin
			div_rem     <= 32'd0;
			div_quo     <= (is_signed && a[31]) ? -a : a;
			div_dvs     <= (is_signed && b[31]) ? -b : b;
			div_neg_q   <= is_signed && (a[31] ^ b[31]);
			div_neg_r   <= is_signed && a[31];
			div_by_zero <= (b == 32'd0);
		end else if (div_act && !div_last) begin
			div_rem <= div_ge ? div_diff[31:0] : div_shift[31:0];
			div_quo <= {div_quo[30:0], div_ge};
		end
	end

	// A zero divisor leaves the dividend magnitude in div_rem
	always_ff @(posedge clk) begin
		if (rst) begin
			hi <= 32'd0;
			lo <= 32'd0;
		end else if (mul_vld) begin
			hi <= mul_prod[63:32];
			lo <= mul_prod[31:0];
		end else if (div_last) begin
			hi <= div_neg_r ? -div_rem : div_rem;
			lo <= div_by_zero ? 32'hffff_ffff : (div_neg_q ? -div_quo : div_quo);
		end
	end

	a_no_start_in_div: assert property (
		@(posedge clk) disable iff (rst) start |-> !div_act
	) else $error("muldiv start during active divide");

	a_div_busy_len: assert property (
		@(posedge clk) disable iff (rst)
		(start && is_div) |=> busy [*DIV_CYCLES] ##1 !busy
	) else $error("divide busy length wrong");

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
	input  logic               clk,
	input  logic               rst,
	input  alu_pkg::exec_req_t req,
	output alu_pkg::exec_rsp_t rsp,
	output logic               busy
);
	import alu_pkg::*;

	alu_ctl_t    ctl;
	logic [31:0] b_sel;
	logic [31:0] alu_result;
	logic        alu_zero;
	logic [31:0] hi;
	logic [31:0] lo;
	logic        md_op;      // Goes to the mul/div unit
	logic        alu_class;  // Produces a response
	logic        md_start;

	assign b_sel     = ctl.use_imm ? ctl.imm_val : req.rt_val;
	assign md_op     = ctl.op inside {ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU};
	assign alu_class = !md_op && (ctl.op != ALU_NOP);
	assign md_start  = req.valid && md_op;

	alu_decoder u_alu_decoder (
		.instr (req.instr),
		.ctl   (ctl)
	);

	alu_core u_alu_core (
		.ctl    (ctl),
		.a      (req.rs_val),
		.b      (b_sel),
		.hi     (hi),
		.lo     (lo),
		.result (alu_result),
		.zero   (alu_zero)
	);

	muldiv_unit u_muldiv_unit (
		.clk   (clk),
		.rst   (rst),
		.start (md_start),
		.op    (ctl.op),
		.a     (req.rs_val),
		.b     (b_sel),
		.busy  (busy),
		.hi    (hi),
		.lo    (lo)
	);

	always_ff @(posedge clk) begin
		rsp.result <= alu_result;
		rsp.zero   <= alu_zero;
		if (rst) begin
			rsp.valid <= 1'b0;
		end else begin
			rsp.valid <= req.valid && alu_class;  // One cycle after issue
		end
	end

	// No back-pressure, so the source has to hold off while busy
	a_no_issue_busy: assert property (
		@(posedge clk) disable iff (rst) req.valid |-> !busy
	) else $error("request issued while busy");

endmodule

`default_nettype wire

//--- tb_execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_execute_stage;
	import mips_isa_pkg::*;
	import alu_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 10;
	localparam int NUM_RANDOM = 200;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] rs_val;
		logic [31:0] rt_val;
		exec_rsp_t   exp;
		int          busy_cycles;  // 0 for ALU-class ops
	} stim_t;

	logic      clk;
	logic      rst;
	exec_req_t req;
	exec_rsp_t rsp;
	logic      busy;

	string stim_names [$];
	stim_t stim [$];
	bit    stim_loaded;

	execute_stage u_execute_stage (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.rsp  (rsp),
		.busy (busy)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation finished: FAIL");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_rsp(input string name, input exec_rsp_t exp, input exec_rsp_t act);
		if (act.valid !== exp.valid ||
			(exp.valid && (act.result !== exp.result || act.zero !== exp.zero))) begin
			stop_on_error($sformatf(
				"Fail %s: expected valid=%0b result=%h zero=%0b, actual valid=%0b result=%h zero=%0b",
				name, exp.valid, exp.result, exp.zero, act.valid, act.result, act.zero));
		end
	endtask

	task automatic check_busy(input string name, input int exp, input int act);
		if (act != exp) begin
			stop_on_error($sformatf("Fail %s: expected busy cycles %0d, actual %0d",
				name, exp, act));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reference behavior for the random R-type mix
	function automatic exec_rsp_t model_rsp(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		exec_rsp_t r;
		logic      less;
		less = (a[31] != b[31]) ? a[31] : (a < b);  // Negative one is less when signs differ
		r.valid = 1'b1;
		case (funct)
			FN_ADDU: r.result = a + b;
			FN_SUBU: r.result = a - b;
			FN_XOR:  r.result = a ^ b;
			default: r.result = {31'b0, less};
		endcase
		r.zero = (r.result == 32'b0);
		return r;
	endfunction

	function automatic logic [5:0] random_funct(input logic [1:0] sel);
		case (sel)
			2'd0:    return FN_ADDU;
			2'd1:    return FN_SUBU;
			2'd2:    return FN_XOR;
			default: return FN_SLT;
		endcase
	endfunction

	task automatic load_stim();
		int          fd;
		int          n;
		int          valid_i;
		int          busy_i;
		int          zero_i;
		string       line;
		string       name;
		logic [31:0] instr;
		logic [31:0] rs_v;
		logic [31:0] rt_v;
		logic [31:0] res;
		stim_t       s;
		fd = $fopen("exec_stim.txt", "r");
		if (fd == 0) begin
			stop_on_error("Could not open the stimulus file exec_stim.txt");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#") begin
				continue;  // Blank or comment line
			end
			n = $sscanf(line, "%s %h %h %h %d %d %h %d", name, instr, rs_v, rt_v,
				valid_i, busy_i, res, zero_i);
			if (n != 8) begin
				stop_on_error({"Stimulus line could not be parsed: ", line});
			end
			s = '0;
			s.instr       = instr;
			s.rs_val      = rs_v;
			s.rt_val      = rt_v;
			s.exp.valid   = valid_i[0];
			s.exp.result  = res;
			s.exp.zero    = zero_i[0];
			s.busy_cycles = busy_i;
			stim_names.push_back(name);
			stim.push_back(s);
		end
		$fclose(fd);
	endtask

	// Called on a falling edge, returns on a falling edge
	task automatic run_request(input string name, input stim_t s);
		exec_rsp_t idle;
		int        cycles;
		idle   = '0;
		cycles = 0;
		while (busy) @(negedge clk);
		req.valid  = 1'b1;
		req.instr  = s.instr;
		req.rs_val = s.rs_val;
		req.rt_val = s.rt_val;
		@(negedge clk);
		req.valid = 1'b0;
		check_rsp(name, s.exp, rsp);
		while (busy) begin
			cycles++;
			@(negedge clk);
			check_rsp({name, " no response while busy"}, idle, rsp);
		end
		check_busy(name, s.busy_cycles, cycles);
		@(negedge clk);
		check_rsp({name, " single response"}, idle, rsp);
	endtask

	initial begin
		longint limit;
		wait (stim_loaded);
		limit = longint'(stim.size() + NUM_RANDOM) * longint'(DIV_CYCLES + 4) * CLK_PERIOD
			+ longint'(RST_CYCLES * CLK_PERIOD);
		#(limit);
		$display("Watchdog timeout: the test sequence did not complete in time");
		$display("Simulation finished: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		logic [31:0] seed;
		logic [31:0] a;
		logic [31:0] b;
		logic [5:0]  funct;
		stim_t       s;
		clk         = 1'b0;
		rst         = 1'b1;
		req         = '0;
		req.valid   = 1'b1;  // Ignored while in reset
		req.instr   = {OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, FN_MULT};
		req.rs_val  = 32'hffff_fffe;
		req.rt_val  = 32'd3;
		stim_loaded = 1'b0;
		seed        = 32'd75468;
		load_stim();
		stim_loaded = 1'b1;
		repeat (RST_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		req.instr = {OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, FN_ADDU};  // ALU op on the last reset edge
		@(negedge clk);
		rst = 1'b0;
		req = '0;
		check_busy("after reset", 0, (busy === 1'b0) ? 0 : 1);
		check_rsp("after reset", '0, rsp);

		foreach (stim[i]) begin
			run_request(stim_names[i], stim[i]);
		end

		for (int i = 0; i < NUM_RANDOM; i++) begin
			seed  = xorshift32(seed);
			a     = seed;
			seed  = xorshift32(seed);
			b     = seed;
			seed  = xorshift32(seed);
			funct = random_funct(seed[1:0]);
			if (seed[7:4] == 4'd0) begin
				b = a;  // Equal operands now and then
			end
			s             = '0;
			s.instr       = {OP_RTYPE, 5'd1, 5'd2, 5'd3, 5'd0, funct};
			s.rs_val      = a;
			s.rt_val      = b;
			s.exp         = model_rsp(funct, a, b);
			s.busy_cycles = 0;
			run_request($sformatf("random_%0d", i), s);
		end

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- exec_stim.txt
# Columns: name instr rs_val rt_val rsp_valid busy_cycles result zero
# instr, operands and result in hex; rsp_valid, busy_cycles and zero in decimal
mfhi_after_reset   00221810 00000000 00000000 1 0 00000000 1
mflo_after_reset   00221812 00000000 00000000 1 0 00000000 1
and                00221824 f0f0ff00 ff00f0f0 1 0 f000f000 0
or                 00221825 f0f0ff00 0000000f 1 0 f0f0ff0f 0
xor_equal          00221826 aaaaaaaa aaaaaaaa 1 0 00000000 1
nor                00221827 0f0f0f0f 00f000f0 1 0 f000f000 0
addu_wrap          00221821 ffffffff 00000001 1 0 00000000 1
subu_borrow        00221823 00000000 00000001 1 0 ffffffff 0
slt_min_max        0022182a 80000000 7fffffff 1 0 00000001 0
sltu_min_max       0022182b 80000000 7fffffff 1 0 00000000 1
slti_neg           2822ffff fffffffe 00000000 1 0 00000001 0
sltiu_sext         2c22ffff 00000005 00000000 1 0 00000001 0
addiu_neg_imm      24228000 00010000 00000000 1 0 00008000 0
andi_zext          3022ffff ffff1234 00000000 1 0 00001234 0
ori                34228001 12340000 00000000 1 0 12348001 0
xori_zext          3822ffff ffffffff 00000000 1 0 ffff0000 0
lui                3c22abcd 12345678 00000000 1 0 abcd0000 0
sll_shamt4         00221900 8000000f 00000000 1 0 000000f0 0
srl_shamt8         00221a02 f0000000 00000000 1 0 00f00000 0
sra_shamt4         00221903 f0000000 00000000 1 0 ff000000 0
sllv_low5          00221804 00000001 0000003f 1 0 80000000 0
srlv_low5          00221806 80000000 00000021 1 0 40000000 0
srav_neg           00221807 80000000 0000001f 1 0 ffffffff 0
jr_pass            00221808 deadbeef 00000000 1 0 deadbeef 0
bltz_min           04200010 80000000 00000000 1 0 00000000 1
bltz_zero          04200010 00000000 00000000 1 0 00000001 0
bgez_zero          04210010 00000000 00000000 1 0 00000000 1
bgez_neg           04210010 ffffffff 00000000 1 0 00000001 0
bgtz_zero          1c200010 00000000 00000000 1 0 00000001 0
bgtz_pos           1c200010 00000001 00000000 1 0 00000000 1
blez_min           18200010 80000000 00000000 1 0 00000000 1
blez_max           18200010 7fffffff 00000000 1 0 00000001 0
beqz_zero          10220010 00000000 00000000 1 0 00000000 1
bnez_min           14220010 80000000 00000000 1 0 00000000 1
lw_unsupported     8c220004 00000000 00000000 0 0 00000000 0
funct_unsupported  00221801 00000000 00000000 0 0 00000000 0
mult_neg           00221818 fffffffe 00000003 0 2 00000000 0
mfhi_mult_neg      00221810 00000000 00000000 1 0 ffffffff 0
mflo_mult_neg      00221812 00000000 00000000 1 0 fffffffa 0
multu_big          00221819 fffffffe 00000003 0 2 00000000 0
mfhi_multu_big     00221810 00000000 00000000 1 0 00000002 0
mflo_multu_big     00221812 00000000 00000000 1 0 fffffffa 0
mult_min_min       00221818 80000000 80000000 0 2 00000000 0
mfhi_mult_min      00221810 00000000 00000000 1 0 40000000 0
mflo_mult_min      00221812 00000000 00000000 1 0 00000000 1
div_neg_dividend   0022181a fffffff9 00000002 0 33 00000000 0
mfhi_div_neg_dvd   00221810 00000000 00000000 1 0 ffffffff 0
mflo_div_neg_dvd   00221812 00000000 00000000 1 0 fffffffd 0
div_neg_divisor    0022181a 00000007 fffffffe 0 33 00000000 0
mfhi_div_neg_dvs   00221810 00000000 00000000 1 0 00000001 0
mflo_div_neg_dvs   00221812 00000000 00000000 1 0 fffffffd 0
divu_big           0022181b ffffffff 00000010 0 33 00000000 0
mfhi_divu_big      00221810 00000000 00000000 1 0 0000000f 0
mflo_divu_big      00221812 00000000 00000000 1 0 0fffffff 0
div_by_zero        0022181a fffffff9 00000000 0 33 00000000 0
mfhi_div_zero      00221810 00000000 00000000 1 0 fffffff9 0
mflo_div_zero      00221812 00000000 00000000 1 0 ffffffff 0
divu_by_zero       0022181b 12345678 00000000 0 33 00000000 0
mfhi_divu_zero     00221810 00000000 00000000 1 0 12345678 0
mflo_divu_zero     00221812 00000000 00000000 1 0 ffffffff 0

//--- verilog.f
mips_isa_pkg.sv
alu_pkg.sv
alu_decoder.sv
alu_core.sv
muldiv_unit.sv
execute_stage.sv
tb_execute_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_execute_stage -f verilog.f -o sim_execute_stage

# The log decides the verdict, so a failing run must not stop the script here
./obj_dir/sim_execute_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	exit 0
fi
exit 1
